//--- list.f
+incdir+.
mips_pkg.sv
reg_file.sv
ctrl_decoder.sv
imm_extend.sv
branch_unit.sv
decode_stage.sv
tb_decode_stage.sv

//--- run_sim.sh
#!/bin/sh
# build the decode stage testbench with verilator and run it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module tb_decode_stage -f list.f \
   || { echo "build failed"; exit 1; }
out=$(./obj_dir/Vtb_decode_stage)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "RESULT: PASS" && echo "simulation passed" && exit 0
echo "simulation failed"
exit 1

//--- tb_decode_stage.sv
`timescale 1ns/1ps
`default_nettype none
`include "mips_defines.svh"

module tb_decode_stage;

   localparam int N_RESET     = 8;
   localparam int N_REGS      = 32 + 31 + 1 + 16;   // zero reads, writes, r0, readback
   localparam int N_IMM       = 60;
   localparam int N_MISC      = 60;
   localparam int N_BRANCH    = 40;
   localparam int N_JUMP      = 40;
   localparam int CYCLE_LIMIT = N_RESET + N_REGS + N_IMM + N_MISC + N_BRANCH + N_JUMP + 4 + 200;

   // redirect outputs seen by fetch
   typedef struct packed {
      logic [`MIPS_XLEN-1:0] brh_addr;
      logic [`MIPS_XLEN-1:0] jmp_addr;
      logic                  take_branch;
      logic                  pc_src;
      logic                  flush;
   } brh_res_t;

   typedef struct packed {
      mips_pkg::id_ex_t id_ex;
      brh_res_t         brh;
   } expect_t;

   logic                   i_clk;
   logic                   i_rst;
   logic [`MIPS_XLEN-1:0]  i_pc;
   logic [`MIPS_XLEN-1:0]  i_instr;
   logic [`MIPS_XLEN-1:0]  i_wb_data;
   logic [`MIPS_REG_W-1:0] i_wb_addr;
   logic                   i_wb_we;
   mips_pkg::id_ex_t       o_id_ex;
   logic [`MIPS_XLEN-1:0]  o_brh_addr;
   logic [`MIPS_XLEN-1:0]  o_jmp_addr;
   logic                   o_take_branch;
   logic                   o_pc_src;
   logic                   o_flush;

   logic [`MIPS_XLEN-1:0]  shadow [`MIPS_NUM_REGS] = '{default: '0};   // mirror of reg file
   expect_t                exp_cur;
   string                  tag_cur;
   logic                   chk_valid;
   mips_pkg::id_ex_t       exp_q [$];   // id/ex results one cycle behind
   string                  tag_q [$];
   int                     cycle_cnt = 0;
   int                     err_id_ex = 0;
   int                     err_ctrl = 0;
   int                     err_branch = 0;

   mips_pkg::opcode_e imm_opc [6] = '{mips_pkg::OPC_ADDI, mips_pkg::OPC_SLTI, mips_pkg::OPC_ANDI,
                                      mips_pkg::OPC_ORI, mips_pkg::OPC_XORI, mips_pkg::OPC_LUI};

   decode_stage decode_stage_inst (
      .i_clk         (i_clk),
      .i_rst         (i_rst),
      .i_pc          (i_pc),
      .i_instr       (i_instr),
      .i_wb_data     (i_wb_data),
      .i_wb_addr     (i_wb_addr),
      .i_wb_we       (i_wb_we),
      .o_id_ex       (o_id_ex),
      .o_brh_addr    (o_brh_addr),
      .o_jmp_addr    (o_jmp_addr),
      .o_take_branch (o_take_branch),
      .o_pc_src      (o_pc_src),
      .o_flush       (o_flush)
   );

   initial begin
      i_clk = 1'b0;
      forever #50 i_clk = ~i_clk;
   end

   always @(posedge i_clk) cycle_cnt <= cycle_cnt + 1;

   // ##################################################################
   // reference model
   // ##################################################################
   function automatic expect_t ref_decode(input logic [31:0] instr, input logic [31:0] pc,
                                          input logic [31:0] rs_v, input logic [31:0] rt_v);
      expect_t         e;
      mips_pkg::ctrl_t c;
      e           = '0;
      c           = '0;
      c.alu_op    = mips_pkg::ALU_NOP;   // unknown opcodes end up here
      c.src_a     = mips_pkg::SRC_A_PC;
      c.dst_sel   = mips_pkg::DST_RD;
      e.id_ex.imm = {{16{instr[15]}}, instr[15:0]};
      case (instr[31:26])
         mips_pkg::OPC_SPECIAL: begin
            e.id_ex.imm = {21'd0, instr[10:0]};   // shamt and funct
            c.alu_op    = mips_pkg::ALU_RTYPE;
            c.src_a     = mips_pkg::SRC_A_SHAMT;
            c.reg_write = 1'b1;
            if (instr[5:0] == mips_pkg::FN_JR || instr[5:0] == mips_pkg::FN_JALR) begin
               e.brh.pc_src   = 1'b1;
               e.brh.flush    = 1'b1;
               e.brh.jmp_addr = rs_v;
               c.alu_op       = mips_pkg::ALU_NOP;
               c.reg_write    = 1'b0;
               if (instr[5:0] == mips_pkg::FN_JALR) begin
                  c.alu_op    = mips_pkg::ALU_LINK;
                  c.src_a     = mips_pkg::SRC_A_PC;
                  c.reg_write = 1'b1;
               end
            end
         end
         mips_pkg::OPC_J, mips_pkg::OPC_JAL: begin
            e.id_ex.imm    = {6'd0, instr[25:0]};
            e.brh.pc_src   = 1'b1;
            e.brh.flush    = 1'b1;
            e.brh.jmp_addr = {pc[31:28], instr[25:0], 2'b00};
            if (instr[31:26] == mips_pkg::OPC_JAL) begin
               c.alu_op    = mips_pkg::ALU_LINK;
               c.dst_sel   = mips_pkg::DST_R31;
               c.reg_write = 1'b1;
            end
         end
         mips_pkg::OPC_BEQ, mips_pkg::OPC_BNE: begin
            c.alu_op          = mips_pkg::ALU_BRANCH;
            c.src_a           = mips_pkg::SRC_A_RS;
            e.brh.flush       = 1'b1;   // taken or not
            e.brh.take_branch = (instr[31:26] == mips_pkg::OPC_BEQ) ? (rs_v == rt_v)
                                                                     : (rs_v != rt_v);
         end
         mips_pkg::OPC_ADDI, mips_pkg::OPC_SLTI, mips_pkg::OPC_ANDI, mips_pkg::OPC_ORI,
         mips_pkg::OPC_XORI, mips_pkg::OPC_LUI, mips_pkg::OPC_LW, mips_pkg::OPC_SW: begin
            c.src_a     = mips_pkg::SRC_A_RS;
            c.src_b_imm = 1'b1;
            c.dst_sel   = mips_pkg::DST_RT;
            c.reg_write = 1'b1;
            case (instr[31:26])
               mips_pkg::OPC_ADDI: c.alu_op = mips_pkg::ALU_ADD;
               mips_pkg::OPC_SLTI: c.alu_op = mips_pkg::ALU_SLT;
               mips_pkg::OPC_ANDI: c.alu_op = mips_pkg::ALU_AND;
               mips_pkg::OPC_ORI:  c.alu_op = mips_pkg::ALU_OR;
               mips_pkg::OPC_XORI: c.alu_op = mips_pkg::ALU_XOR;
               mips_pkg::OPC_LUI:  c.alu_op = mips_pkg::ALU_LUI;
               mips_pkg::OPC_LW: begin
                  c.alu_op   = mips_pkg::ALU_ADD;
                  c.mem_read = 1'b1;
               end
               default: begin   // sw
                  c.alu_op    = mips_pkg::ALU_ADD;
                  c.reg_write = 1'b0;
                  c.mem_write = 1'b1;
               end
            endcase
            if (c.alu_op inside {mips_pkg::ALU_AND, mips_pkg::ALU_OR, mips_pkg::ALU_XOR,
                                 mips_pkg::ALU_LUI}) begin
               e.id_ex.imm = {16'd0, instr[15:0]};   // logical ops zero-extend
            end
         end
         default: ;
      endcase
      e.brh.brh_addr = pc + (e.id_ex.imm << 2);
      e.id_ex.pc     = pc;
      e.id_ex.rs_val = rs_v;
      e.id_ex.rt_val = rt_v;
      e.id_ex.rt_num = instr[20:16];
      e.id_ex.rd_num = instr[15:11];
      e.id_ex.ctrl   = c;
      return e;
   endfunction

   // shadow read with the same-cycle writeback bypass
   function automatic logic [31:0] read_shadow(input logic [4:0] addr, input logic we,
                                               input logic [4:0] waddr, input logic [31:0] wdata);
      if (addr == 5'd0) return '0;
      if (we && waddr == addr) return wdata;
      return shadow[addr];
   endfunction

   function automatic logic is_known_opc(input logic [5:0] opc);
      case (opc)
         mips_pkg::OPC_SPECIAL, mips_pkg::OPC_J, mips_pkg::OPC_JAL, mips_pkg::OPC_BEQ,
         mips_pkg::OPC_BNE, mips_pkg::OPC_ADDI, mips_pkg::OPC_SLTI, mips_pkg::OPC_ANDI,
         mips_pkg::OPC_ORI, mips_pkg::OPC_XORI, mips_pkg::OPC_LUI, mips_pkg::OPC_LW,
         mips_pkg::OPC_SW: return 1'b1;
         default:          return 1'b0;
      endcase
   endfunction

   function automatic logic [31:0] rand_pc();
      logic [31:0] r;
      r = $urandom();
      return {r[31:2], 2'b00};   // word aligned
   endfunction

   function automatic logic [31:0] make_rtype(input logic [4:0] rs, input logic [4:0] rt,
                                              input logic [5:0] fn);
      return {mips_pkg::OPC_SPECIAL, rs, rt, 5'd3, 5'd7, fn};
   endfunction

   // ##################################################################
   // compare tasks
   // ##################################################################
   task automatic check_ctrl(input mips_pkg::ctrl_t got, input mips_pkg::ctrl_t exp,
                             input string tag);
      if (got !== exp) begin
         err_ctrl++;
         $display("FAIL t=%0t %s: ctrl got %h expected %h", $time, tag, got, exp);
      end
   endtask

   task automatic check_id_ex(input mips_pkg::id_ex_t got, input mips_pkg::id_ex_t exp,
                              input string tag);
      if (got.pc !== exp.pc || got.rs_val !== exp.rs_val || got.rt_val !== exp.rt_val ||
          got.imm !== exp.imm || got.rt_num !== exp.rt_num || got.rd_num !== exp.rd_num) begin
         err_id_ex++;
         $display("FAIL t=%0t %s: id_ex got %h expected %h", $time, tag, got, exp);
      end
      check_ctrl(got.ctrl, exp.ctrl, tag);
   endtask

   task automatic check_branch(input brh_res_t got, input brh_res_t exp, input string tag);
      if (got.brh_addr !== exp.brh_addr || got.take_branch !== exp.take_branch ||
          got.pc_src !== exp.pc_src || got.flush !== exp.flush ||
          (exp.pc_src && got.jmp_addr !== exp.jmp_addr)) begin
         err_branch++;
         $display("FAIL t=%0t %s: branch got %h expected %h", $time, tag, got, exp);
      end
   endtask

   always @(posedge i_clk) begin : compare_comb   // inputs settled since the falling edge
      brh_res_t got;
      got = '{o_brh_addr, o_jmp_addr, o_take_branch, o_pc_src, o_flush};
      if (chk_valid) begin
         check_branch(got, exp_cur.brh, tag_cur);
         exp_q.push_back(exp_cur.id_ex);
         tag_q.push_back(tag_cur);
      end
   end

   always @(negedge i_clk) begin   // id/ex settled since the rising edge
      if (exp_q.size() > 0) check_id_ex(o_id_ex, exp_q.pop_front(), tag_q.pop_front());
   end

   // ##################################################################
   // stimulus
   // ##################################################################
   task automatic drive_cycle(input logic [31:0] pc, input logic [31:0] instr, input logic we,
                              input logic [4:0] waddr, input logic [31:0] wdata, input string tag);
      logic [31:0] rs_v;
      logic [31:0] rt_v;
      @(negedge i_clk);
      i_pc      = pc;
      i_instr   = instr;
      i_wb_we   = we;
      i_wb_addr = waddr;
      i_wb_data = wdata;
      rs_v      = read_shadow(instr[25:21], we, waddr, wdata);
      rt_v      = read_shadow(instr[20:16], we, waddr, wdata);
      exp_cur   = ref_decode(instr, pc, rs_v, rt_v);
      tag_cur   = tag;
      chk_valid = 1'b1;
      if (we && waddr != 5'd0) shadow[waddr] = wdata;   // lands at the next edge
   endtask

   task automatic drive_random_wb(input logic [31:0] instr, input string tag);
      logic [31:0] r;
      r = $urandom();
      drive_cycle(rand_pc(), instr, r[31], r[4:0], $urandom(), tag);
   endtask

   task automatic apply_reset();
      logic [31:0] r;
      r         = $urandom();
      i_rst     = 1'b1;
      i_instr   = {mips_pkg::OPC_ADDI, r[25:0]};
      i_wb_we   = 1'b1;   // dropped while reset is high
      i_wb_addr = 5'd5;
      i_wb_data = r;
      repeat (N_RESET) @(posedge i_clk);
      @(negedge i_clk);
      check_id_ex(o_id_ex, '0, "after reset");
      i_rst   = 1'b0;
      i_wb_we = 1'b0;
   endtask

   initial begin : stimulus
      logic [31:0] r;
      logic [4:0]  rs;
      logic [4:0]  rt;
      void'($urandom(32'hf6150483));
      i_rst     = 1'b1;
      i_pc      = '0;
      i_instr   = '0;
      i_wb_data = '0;
      i_wb_addr = '0;
      i_wb_we   = 1'b0;
      chk_valid = 1'b0;
      apply_reset();

      for (int i = 0; i < 32; i++) begin   // every register reads zero
         drive_cycle(32'h0040_0000 + 4 * i, make_rtype(i[4:0], 5'(31 - i), 6'h20), 1'b0,
                     5'd0, '0, "zero read");
      end
      for (int i = 1; i < 32; i++) begin   // rs hits the bypass, rt the stored value
         drive_cycle(rand_pc(), make_rtype(i[4:0], 5'(i - 1), 6'h20), 1'b1, i[4:0],
                     $urandom(), "write bypass");
      end
      drive_cycle(rand_pc(), make_rtype(5'd0, 5'd0, 6'h20), 1'b1, 5'd0, $urandom(), "r0 write");
      for (int i = 0; i < 16; i++) begin
         drive_cycle(rand_pc(), make_rtype(5'(2 * i), 5'(2 * i + 1), 6'h20), 1'b0, 5'd0, '0,
                     "readback");
      end

      for (int i = 0; i < N_IMM; i++) begin
         r = $urandom();
         drive_random_wb({imm_opc[$urandom_range(0, 5)], r[25:0]}, "imm op");
      end

      for (int i = 0; i < N_MISC; i++) begin   // lw/sw, r-type alu, unknown
         r = $urandom();
         if (i % 3 == 0) begin
            drive_random_wb({r[31] ? mips_pkg::OPC_LW : mips_pkg::OPC_SW, r[25:0]}, "lw sw");
         end else if (i % 3 == 1) begin
            if (r[5:0] == mips_pkg::FN_JR || r[5:0] == mips_pkg::FN_JALR) r[5:0] = 6'h20;
            drive_random_wb({mips_pkg::OPC_SPECIAL, r[25:0]}, "special alu");
         end else begin
            while (is_known_opc(r[31:26])) r = $urandom();
            drive_random_wb(r, "unknown opcode");
         end
      end

      for (int i = 0; i < N_BRANCH; i++) begin   // odd i unequal, bit 1 of i picks beq
         r  = $urandom();
         rs = 5'($urandom_range(1, 31));
         rt = (rs == 5'd31) ? 5'd1 : rs + 5'd1;
         drive_cycle(rand_pc(), {i[1] ? mips_pkg::OPC_BEQ : mips_pkg::OPC_BNE, rs, rt, r[15:0]},
                     1'b1, rt, i[0] ? (shadow[rs] ^ ($urandom() | 32'd1)) : shadow[rs], "branch");
      end

      for (int i = 0; i < N_JUMP; i++) begin
         r = $urandom();
         case (i % 4)
            0:       drive_random_wb({mips_pkg::OPC_J, r[25:0]}, "j");
            1:       drive_random_wb({mips_pkg::OPC_JAL, r[25:0]}, "jal");
            2:       drive_random_wb({mips_pkg::OPC_SPECIAL, r[25:6], mips_pkg::FN_JR}, "jr");
            default: drive_random_wb({mips_pkg::OPC_SPECIAL, r[25:6], mips_pkg::FN_JALR}, "jalr");
         endcase
      end

      @(negedge i_clk);
      chk_valid = 1'b0;
      i_wb_we   = 1'b0;
      @(negedge i_clk);
      $display("errors: id_ex %0d, ctrl %0d, branch %0d", err_id_ex, err_ctrl, err_branch);
      if (err_id_ex + err_ctrl + err_branch == 0) begin
         $display("RESULT: PASS");
      end else begin
         $display("RESULT: FAIL");
      end
      $finish;
   end

   initial begin : watchdog
      wait (cycle_cnt >= CYCLE_LIMIT);
      $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("RESULT: FAIL");
      $finish;
   end

endmodule

`default_nettype wire

//--- decode_stage.sv
`timescale 1ns/1ps
`default_nettype none
`include "mips_defines.svh"

module decode_stage (
   input  wire                     i_clk,
   input  wire                     i_rst,
   input  wire [`MIPS_XLEN-1:0]    i_pc,
   input  wire [`MIPS_XLEN-1:0]    i_instr,
   input  wire [`MIPS_XLEN-1:0]    i_wb_data,
   input  wire [`MIPS_REG_W-1:0]   i_wb_addr,
   input  wire                     i_wb_we,
   output mips_pkg::id_ex_t        o_id_ex,
   output logic [`MIPS_XLEN-1:0]   o_brh_addr,
   output logic [`MIPS_XLEN-1:0]   o_jmp_addr,
   output logic                    o_take_branch,
   output logic                    o_pc_src,
   output logic                    o_flush
);

   mips_pkg::ctrl_t       ctrl;
   mips_pkg::ext_mode_e   ext_mode;
   mips_pkg::jump_kind_e  jump_kind;
   mips_pkg::id_ex_t      id_ex_d;
   logic [`MIPS_XLEN-1:0] imm;
   logic [`MIPS_XLEN-1:0] rs_val;
   logic [`MIPS_XLEN-1:0] rt_val;
   logic                  rs_eq_rt;

   // ##################################################################
   // decode blocks
   // ##################################################################
   reg_file reg_file_inst (
      .i_clk     (i_clk),
      .i_rst     (i_rst),
      .i_rs_addr (i_instr[`MIPS_RS_LSB +: `MIPS_REG_W]),
      .i_rt_addr (i_instr[`MIPS_RT_LSB +: `MIPS_REG_W]),
      .i_wr_addr (i_wb_addr),
      .i_wr_data (i_wb_data),
      .i_wr_en   (i_wb_we),
      .o_rs_val  (rs_val),
      .o_rt_val  (rt_val),
      .o_equal   (rs_eq_rt)
   );

   ctrl_decoder ctrl_decoder_inst (
      .i_instr     (i_instr),
      .o_ctrl      (ctrl),
      .o_ext_mode  (ext_mode),
      .o_jump_kind (jump_kind)
   );

   imm_extend imm_extend_inst (
      .i_instr (i_instr),
      .i_mode  (ext_mode),
      .o_imm   (imm)
   );

   branch_unit branch_unit_inst (   // same-cycle redirect to fetch
      .i_kind        (jump_kind),
      .i_pc          (i_pc),
      .i_imm         (imm),
      .i_rs_val      (rs_val),
      .i_equal       (rs_eq_rt),
      .o_brh_addr    (o_brh_addr),
      .o_jmp_addr    (o_jmp_addr),
      .o_take_branch (o_take_branch),
      .o_pc_src      (o_pc_src),
      .o_flush       (o_flush)
   );

   // ##################################################################
   // id/ex register
   // ##################################################################
   always_comb begin
      id_ex_d.pc     = i_pc;
      id_ex_d.rs_val = rs_val;
      id_ex_d.rt_val = rt_val;
      id_ex_d.imm    = imm;
      id_ex_d.rt_num = i_instr[`MIPS_RT_LSB +: `MIPS_REG_W];
      id_ex_d.rd_num = i_instr[`MIPS_RD_LSB +: `MIPS_REG_W];
      id_ex_d.ctrl   = ctrl;
   end

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         o_id_ex <= '0;      // clears reg_write and the mem strobes
      end else begin
         o_id_ex <= id_ex_d;
      end
   end

endmodule

`default_nettype wire

//--- branch_unit.sv
`timescale 1ns/1ps
`default_nettype none
`include "mips_defines.svh"

module branch_unit (
   input  mips_pkg::jump_kind_e    i_kind,
   input  wire [`MIPS_XLEN-1:0]    i_pc,
   input  wire [`MIPS_XLEN-1:0]    i_imm,
   input  wire [`MIPS_XLEN-1:0]    i_rs_val,
   input  wire                     i_equal,
   output logic [`MIPS_XLEN-1:0]   o_brh_addr,
   output logic [`MIPS_XLEN-1:0]   o_jmp_addr,
   output logic                    o_take_branch,
   output logic                    o_pc_src,
   output logic                    o_flush
);

   logic [`MIPS_XLEN-1:0] region_addr;   // pc region + index

   assign o_brh_addr = i_pc + (i_imm << 2);

   assign region_addr = {i_pc[`MIPS_XLEN-1 -: `MIPS_JMP_HI_W],
                         i_imm[`MIPS_IDX_W-1:0], 2'b00};

   assign o_jmp_addr = (i_kind == mips_pkg::JK_JUMP_REG) ? i_rs_val : region_addr;

   // beq on equal, bne on differ
   assign o_take_branch = ((i_kind == mips_pkg::JK_BEQ) &&  i_equal) ||
                          ((i_kind == mips_pkg::JK_BNE) && !i_equal);

   assign o_pc_src = (i_kind == mips_pkg::JK_JUMP) ||
                     (i_kind == mips_pkg::JK_JUMP_REG);

   // the slot behind any branch or jump is dropped, taken or not
   assign o_flush = (i_kind != mips_pkg::JK_NONE);

endmodule

`default_nettype wire

//--- imm_extend.sv
`timescale 1ns/1ps
`default_nettype none
`include "mips_defines.svh"

module imm_extend (
   input  wire [`MIPS_XLEN-1:0]    i_instr,
   input  mips_pkg::ext_mode_e     i_mode,
   output logic [`MIPS_XLEN-1:0]   o_imm
);

   logic [`MIPS_IMM_W-1:0] imm16;

   assign imm16 = i_instr[`MIPS_IMM_W-1:0];

   always_comb begin
      case (i_mode)
         mips_pkg::EXT_JUMP:
            o_imm = {{(`MIPS_XLEN-`MIPS_IDX_W){1'b0}}, i_instr[`MIPS_IDX_W-1:0]};
         mips_pkg::EXT_SIGN:
            o_imm = {{(`MIPS_XLEN-`MIPS_IMM_W){imm16[`MIPS_IMM_W-1]}}, imm16};
         mips_pkg::EXT_ZERO:
            o_imm = {{(`MIPS_XLEN-`MIPS_IMM_W){1'b0}}, imm16};
         mips_pkg::EXT_SPECIAL:   // shamt and funct from bits 10:0
            o_imm = {{(`MIPS_XLEN-`MIPS_RD_LSB){1'b0}}, i_instr[`MIPS_RD_LSB-1:0]};
         default:
            o_imm = '0;
      endcase
   end

endmodule

`default_nettype wire

//--- ctrl_decoder.sv
`timescale 1ns/1ps
`default_nettype none
`include "mips_defines.svh"

module ctrl_decoder (
   input  wire [`MIPS_XLEN-1:0]     i_instr,
   output mips_pkg::ctrl_t          o_ctrl,
   output mips_pkg::ext_mode_e      o_ext_mode,
   output mips_pkg::jump_kind_e     o_jump_kind
);

   mips_pkg::opcode_e opcode;
   mips_pkg::funct_e  funct;

   assign opcode = mips_pkg::opcode_e'(i_instr[`MIPS_OPC_LSB +: `MIPS_OPC_W]);
   assign funct  = mips_pkg::funct_e'(i_instr[`MIPS_FUNCT_LSB +: `MIPS_OPC_W]);

   // rs op imm into rt for the immediate alu ops and lw/sw
   function automatic mips_pkg::ctrl_t imm_ctrl(input mips_pkg::alu_op_e op);
      mips_pkg::ctrl_t c;
      c           = '0;
      c.alu_op    = op;
      c.src_a     = mips_pkg::SRC_A_RS;
      c.src_b_imm = 1'b1;
      c.dst_sel   = mips_pkg::DST_RT;
      c.reg_write = 1'b1;
      return c;
   endfunction

   // ##################################################################
   // main decode
   // ##################################################################
   always_comb begin
      // defaults give a nop with no writes
      o_ctrl           = '0;
      o_ctrl.alu_op    = mips_pkg::ALU_NOP;
      o_ctrl.src_a     = mips_pkg::SRC_A_PC;
      o_ctrl.dst_sel   = mips_pkg::DST_RD;
      o_ext_mode       = mips_pkg::EXT_SIGN;
      o_jump_kind      = mips_pkg::JK_NONE;

      case (opcode)
         mips_pkg::OPC_SPECIAL: begin
            o_ext_mode       = mips_pkg::EXT_SPECIAL;
            o_ctrl.alu_op    = mips_pkg::ALU_RTYPE;
            o_ctrl.src_a     = mips_pkg::SRC_A_SHAMT;   // B stays rt
            o_ctrl.dst_sel   = mips_pkg::DST_RD;
            o_ctrl.reg_write = 1'b1;
            if (funct == mips_pkg::FN_JR) begin
               o_jump_kind      = mips_pkg::JK_JUMP_REG;
               o_ctrl.alu_op    = mips_pkg::ALU_NOP;
               o_ctrl.reg_write = 1'b0;                  // plain jr links nothing
            end else if (funct == mips_pkg::FN_JALR) begin
               o_jump_kind      = mips_pkg::JK_JUMP_REG;
               o_ctrl.alu_op    = mips_pkg::ALU_LINK;
               o_ctrl.src_a     = mips_pkg::SRC_A_PC;
            end
         end
         mips_pkg::OPC_J: begin
            o_ext_mode  = mips_pkg::EXT_JUMP;
            o_jump_kind = mips_pkg::JK_JUMP;
         end
         mips_pkg::OPC_JAL: begin
            o_ext_mode       = mips_pkg::EXT_JUMP;
            o_jump_kind      = mips_pkg::JK_JUMP;
            o_ctrl.alu_op    = mips_pkg::ALU_LINK;
            o_ctrl.dst_sel   = mips_pkg::DST_R31;
            o_ctrl.reg_write = 1'b1;
         end
         mips_pkg::OPC_BEQ, mips_pkg::OPC_BNE: begin
            o_ctrl.alu_op = mips_pkg::ALU_BRANCH;
            o_ctrl.src_a  = mips_pkg::SRC_A_RS;
            o_jump_kind   = (opcode == mips_pkg::OPC_BEQ) ? mips_pkg::JK_BEQ
                                                          : mips_pkg::JK_BNE;
         end
         mips_pkg::OPC_ADDI: o_ctrl = imm_ctrl(mips_pkg::ALU_ADD);
         mips_pkg::OPC_SLTI: o_ctrl = imm_ctrl(mips_pkg::ALU_SLT);
         mips_pkg::OPC_ANDI: begin
            o_ctrl     = imm_ctrl(mips_pkg::ALU_AND);
            o_ext_mode = mips_pkg::EXT_ZERO;
         end
         mips_pkg::OPC_ORI: begin
            o_ctrl     = imm_ctrl(mips_pkg::ALU_OR);
            o_ext_mode = mips_pkg::EXT_ZERO;
         end
         mips_pkg::OPC_XORI: begin
            o_ctrl     = imm_ctrl(mips_pkg::ALU_XOR);
            o_ext_mode = mips_pkg::EXT_ZERO;
         end
         mips_pkg::OPC_LUI: begin
            o_ctrl     = imm_ctrl(mips_pkg::ALU_LUI);
            o_ext_mode = mips_pkg::EXT_ZERO;    // execute shifts it up
         end
         mips_pkg::OPC_LW: begin
            o_ctrl          = imm_ctrl(mips_pkg::ALU_ADD);   // base + offset
            o_ctrl.mem_read = 1'b1;
         end
         mips_pkg::OPC_SW: begin
            o_ctrl           = imm_ctrl(mips_pkg::ALU_ADD);
            o_ctrl.reg_write = 1'b0;
            o_ctrl.mem_write = 1'b1;
         end
         default: ;   // keep the nop
      endcase
   end

endmodule

`default_nettype wire

//--- reg_file.sv
`timescale 1ns/1ps
`default_nettype none
`include "mips_defines.svh"

module reg_file (
   input  wire                    i_clk,
   input  wire                    i_rst,
   input  wire [`MIPS_REG_W-1:0]  i_rs_addr,
   input  wire [`MIPS_REG_W-1:0]  i_rt_addr,
   input  wire [`MIPS_REG_W-1:0]  i_wr_addr,
   input  wire [`MIPS_XLEN-1:0]   i_wr_data,
   input  wire                    i_wr_en,
   output logic [`MIPS_XLEN-1:0]  o_rs_val,
   output logic [`MIPS_XLEN-1:0]  o_rt_val,
   output logic                   o_equal
);

   logic [`MIPS_XLEN-1:0] regs [`MIPS_NUM_REGS];
   logic                  wr_ok;

   assign wr_ok = i_wr_en && (i_wr_addr != '0);   // r0 never takes a write

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         for (int i = 0; i < `MIPS_NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (wr_ok) begin
         regs[i_wr_addr] <= i_wr_data;
      end
   end

   // writeback data bypasses the array in the same cycle
   assign o_rs_val = (i_rs_addr == '0)                  ? '0        :
                     (wr_ok && i_wr_addr == i_rs_addr)  ? i_wr_data :
                                                          regs[i_rs_addr];
   assign o_rt_val = (i_rt_addr == '0)                  ? '0        :
                     (wr_ok && i_wr_addr == i_rt_addr)  ? i_wr_data :
                                                          regs[i_rt_addr];

   assign o_equal = (o_rs_val == o_rt_val);   // for beq / bne

endmodule

`default_nettype wire

//--- mips_pkg.sv
`default_nettype none
`include "mips_defines.svh"

package mips_pkg;

   // ##################################################################
   // instruction encodings
   // ##################################################################
   typedef enum logic [`MIPS_OPC_W-1:0] {
      OPC_SPECIAL = 6'b000000,
      OPC_J       = 6'b000010,
      OPC_JAL     = 6'b000011,
      OPC_BEQ     = 6'b000100,
      OPC_BNE     = 6'b000101,
      OPC_ADDI    = 6'b001000,
      OPC_SLTI    = 6'b001010,
      OPC_ANDI    = 6'b001100,
      OPC_ORI     = 6'b001101,
      OPC_XORI    = 6'b001110,
      OPC_LUI     = 6'b001111,
      OPC_LW      = 6'b100011,
      OPC_SW      = 6'b101011
   } opcode_e;

   // only the register jumps matter to decode
   typedef enum logic [`MIPS_OPC_W-1:0] {
      FN_JR   = 6'b001000,
      FN_JALR = 6'b001001
   } funct_e;

   // ##################################################################
   // control encodings
   // ##################################################################
   typedef enum logic [3:0] {
      ALU_ADD    = 4'b0000,
      ALU_BRANCH = 4'b0001,
      ALU_RTYPE  = 4'b0010,   // execute looks at funct
      ALU_SLT    = 4'b0011,
      ALU_AND    = 4'b0100,
      ALU_OR     = 4'b0101,
      ALU_XOR    = 4'b0110,
      ALU_LUI    = 4'b0111,
      ALU_NOP    = 4'b1000,
      ALU_LINK   = 4'b1001    // pc + 8 into the link reg
   } alu_op_e;

   typedef enum logic [1:0] {
      EXT_JUMP    = 2'd0,
      EXT_SIGN    = 2'd1,
      EXT_ZERO    = 2'd2,
      EXT_SPECIAL = 2'd3      // shamt and funct
   } ext_mode_e;

   typedef enum logic [1:0] {SRC_A_PC, SRC_A_RS, SRC_A_SHAMT} src_a_e;
   typedef enum logic [1:0] {DST_RD, DST_RT, DST_R31} dst_sel_e;
   typedef enum logic [2:0] {JK_NONE, JK_BEQ, JK_BNE, JK_JUMP, JK_JUMP_REG} jump_kind_e;

   typedef struct packed {
      alu_op_e  alu_op;
      src_a_e   src_a;
      logic     src_b_imm;   // 1 picks the immediate over rt
      dst_sel_e dst_sel;
      logic     mem_read;
      logic     mem_write;
      logic     reg_write;
   } ctrl_t;

   typedef struct packed {
      logic [`MIPS_XLEN-1:0]  pc;
      logic [`MIPS_XLEN-1:0]  rs_val;
      logic [`MIPS_XLEN-1:0]  rt_val;
      logic [`MIPS_XLEN-1:0]  imm;
      logic [`MIPS_REG_W-1:0] rt_num;
      logic [`MIPS_REG_W-1:0] rd_num;
      ctrl_t                  ctrl;
   } id_ex_t;

endpackage

`default_nettype wire

//--- mips_defines.svh
`ifndef MIPS_DEFINES_SVH
`define MIPS_DEFINES_SVH

// datapath widths
`define MIPS_XLEN       32
`define MIPS_REG_W      5
`define MIPS_NUM_REGS   32

// instruction field widths
`define MIPS_IMM_W      16
`define MIPS_IDX_W      26
`define MIPS_OPC_W      6

// lsb of each instruction field
`define MIPS_OPC_LSB    26
`define MIPS_RS_LSB     21
`define MIPS_RT_LSB     16
`define MIPS_RD_LSB     11   // rd, shamt and funct sit below this bit
`define MIPS_FUNCT_LSB  0

// pc bits kept above a jump index
`define MIPS_JMP_HI_W   (`MIPS_XLEN - `MIPS_IDX_W - 2)

`endif
